/* logic/rvIsaPkg.sv */
package rvIsaPkg;

    // Major opcodes handled by the decode stage
    typedef enum logic [6:0]
    {
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_BRANCH = 7'b1100011,
        OP_AUIPC  = 7'b0010111,
        OP_LUI    = 7'b0110111,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcodeT;

    // Arithmetic group, shared by the R and I forms
    localparam logic [2:0] F3_ADD  = 3'b000; // add, sub, addi
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // srl or sra by funct7 bit 5
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Branch group
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

endpackage

/* logic/ctrlPkg.sv */
package ctrlPkg;

    // Coarse operation class from the main decoder
    typedef enum logic [2:0]
    {
        ALUOP_ADD    = 3'b000, // Load/store address
        ALUOP_BRANCH = 3'b001, // Compare
        ALUOP_FUNCT  = 3'b010, // R and I arithmetic
        ALUOP_JALR   = 3'b011, // Jump target add
        ALUOP_UPPER  = 3'b100  // LUI, AUIPC, JAL
    } aluOpT;

    // Concrete ALU operation handed to execute
    typedef enum logic [3:0]
    {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_AND   = 4'd2,
        ALU_OR    = 4'd3,
        ALU_XOR   = 4'd4,
        ALU_SLT   = 4'd5,
        ALU_SLTU  = 4'd6,
        ALU_SLL   = 4'd7,
        ALU_SRL   = 4'd8,
        ALU_SRA   = 4'd9,
        ALU_PASSB = 4'd10
    } aluCtrlT;

    typedef enum logic [2:0]
    {
        IMM_I = 3'b000,
        IMM_S = 3'b001,
        IMM_B = 3'b010,
        IMM_U = 3'b011,
        IMM_J = 3'b100
    } immSrcT;

    // Write-back source select
    typedef enum logic [1:0]
    {
        RES_ALU   = 2'b00,
        RES_MEM   = 2'b01,
        RES_PCIMM = 2'b10,
        RES_PC4   = 2'b11
    } resultSrcT;

endpackage

/* logic/mainDecoder.sv */
`timescale 1ns/1ps

module mainDecoder
(
    input  rvIsaPkg::opcodeT   op,

    output logic               regWrite,
    output ctrlPkg::immSrcT    immSrc,
    output logic               aluSrc,
    output logic               memWrite,
    output ctrlPkg::resultSrcT resultSrc,
    output logic               branch,
    output ctrlPkg::aluOpT     aluOp,
    output logic               jump,
    output logic               illegal
);
    import rvIsaPkg::*;
    import ctrlPkg::*;

    always_comb
    begin
        // Defaults are the bubble values
        regWrite  = 1'b0;
        immSrc    = IMM_I;
        aluSrc    = 1'b0;
        memWrite  = 1'b0;
        resultSrc = RES_ALU;
        branch    = 1'b0;
        aluOp     = ALUOP_ADD;
        jump      = 1'b0;
        illegal   = 1'b0;

        case (op)
            OP_LOAD:
            begin
                regWrite  = 1'b1;
                aluSrc    = 1'b1;
                resultSrc = RES_MEM;
            end
            OP_STORE:
            begin
                immSrc    = IMM_S;
                aluSrc    = 1'b1;
                memWrite  = 1'b1;
            end
            OP_REG:
            begin
                regWrite  = 1'b1;
                aluOp     = ALUOP_FUNCT;
            end
            OP_IMM:
            begin
                regWrite  = 1'b1;
                aluSrc    = 1'b1;
                aluOp     = ALUOP_FUNCT;
            end
            OP_BRANCH:
            begin
                immSrc    = IMM_B;
                branch    = 1'b1;
                aluOp     = ALUOP_BRANCH;
            end
            OP_AUIPC:
            begin
                regWrite  = 1'b1;
                immSrc    = IMM_U;
                aluSrc    = 1'b1;
                resultSrc = RES_PCIMM; // pc + imm
                aluOp     = ALUOP_UPPER;
            end
            OP_LUI:
            begin
                regWrite  = 1'b1;
                immSrc    = IMM_U;
                aluSrc    = 1'b1;
                aluOp     = ALUOP_UPPER;
            end
            OP_JALR:
            begin
                regWrite  = 1'b1;
                aluSrc    = 1'b1;
                resultSrc = RES_PC4; // Link address
                aluOp     = ALUOP_JALR;
                jump      = 1'b1;
            end
            OP_JAL:
            begin
                regWrite  = 1'b1;
                immSrc    = IMM_J;
                resultSrc = RES_PC4;
                aluOp     = ALUOP_UPPER;
                jump      = 1'b1;
            end
            default:
            begin
                illegal   = 1'b1; // Everything else stays zero
            end
        endcase
    end

    // Both jumps write the link register
    always_comb
    begin
        assert (!jump || regWrite)
        else $error("mainDecoder: jump without regWrite, op %b", op);
    end

endmodule

/* logic/aluDecoder.sv */
`timescale 1ns/1ps

module aluDecoder
(
    input  ctrlPkg::aluOpT   aluOp,
    input  logic [2:0]       funct3,
    input  logic             funct7b5,
    input  logic             op5,

    output ctrlPkg::aluCtrlT aluControl
);
    import rvIsaPkg::*;
    import ctrlPkg::*;

    always_comb
    begin
        aluControl = ALU_ADD;

        case (aluOp)
            ALUOP_ADD,
            ALUOP_JALR:
            begin
                aluControl = ALU_ADD;
            end
            ALUOP_UPPER:
            begin
                aluControl = ALU_PASSB; // Immediate straight through
            end
            ALUOP_BRANCH:
            begin
                case (funct3)
                    F3_BEQ, F3_BNE:   aluControl = ALU_SUB;
                    F3_BLT, F3_BGE:   aluControl = ALU_SLT;
                    F3_BLTU, F3_BGEU: aluControl = ALU_SLTU;
                    default:          aluControl = ALU_SUB;
                endcase
            end
            ALUOP_FUNCT:
            begin
                case (funct3)
                    F3_ADD:
                    begin
                        // Only the R form has sub, addi keeps bit 30 as immediate
                        aluControl = (op5 && funct7b5) ? ALU_SUB : ALU_ADD;
                    end
                    F3_SR:
                    begin
                        aluControl = funct7b5 ? ALU_SRA : ALU_SRL;
                    end
                    F3_SLL:  aluControl = ALU_SLL;
                    F3_SLT:  aluControl = ALU_SLT;
                    F3_SLTU: aluControl = ALU_SLTU;
                    F3_XOR:  aluControl = ALU_XOR;
                    F3_OR:   aluControl = ALU_OR;
                    F3_AND:  aluControl = ALU_AND;
                    default: aluControl = ALU_ADD;
                endcase
            end
            default:
            begin
                aluControl = ALU_ADD;
            end
        endcase
    end

endmodule

/* logic/immExtend.sv */
`timescale 1ns/1ps

module immExtend
#(
    parameter int XLEN = 32
)
(
    input  logic [31:0]     instr,
    input  ctrlPkg::immSrcT immSrc,

    output logic [XLEN-1:0] immExt
);
    import ctrlPkg::*;

    logic sign;

    assign sign = instr[31];

    always_comb
    begin
        case (immSrc)
            IMM_I:
                immExt = {{(XLEN-12){sign}}, instr[31:20]};
            IMM_S:
                immExt = {{(XLEN-12){sign}}, instr[31:25], instr[11:7]};
            IMM_B:
                // Bit 12 comes from the sign run
                immExt = {{(XLEN-12){sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            IMM_U:
                immExt = {{(XLEN-31){sign}}, instr[30:12], 12'b0};
            IMM_J:
                immExt = {{(XLEN-20){sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default:
                immExt = '0;
        endcase
    end

endmodule

/* logic/decodeReg.sv */
`timescale 1ns/1ps

module decodeReg
#(
    parameter int XLEN = 32
)
(
    input  logic               clk,
    input  logic               rstN,
    input  logic               stall,
    input  logic               flush,
    input  logic               instrValid,

    input  logic               regWriteD,
    input  logic               memWriteD,
    input  logic               aluSrcD,
    input  logic               branchD,
    input  logic               jumpD,
    input  logic               illegalD,
    input  ctrlPkg::resultSrcT resultSrcD,
    input  ctrlPkg::aluCtrlT   aluControlD,
    input  logic [XLEN-1:0]    immExtD,
    input  logic [4:0]         rs1D,
    input  logic [4:0]         rs2D,
    input  logic [4:0]         rdD,

    output logic               decValid,
    output logic               regWriteE,
    output logic               memWriteE,
    output logic               aluSrcE,
    output logic               branchE,
    output logic               jumpE,
    output logic               illegalE,
    output ctrlPkg::resultSrcT resultSrcE,
    output ctrlPkg::aluCtrlT   aluControlE,
    output logic [XLEN-1:0]    immExtE,
    output logic [4:0]         rs1E,
    output logic [4:0]         rs2E,
    output logic [4:0]         rdE
);
    import ctrlPkg::*;

    logic loadEn;
    logic bubble;

    assign loadEn = flush || !stall;      // Flush wins over stall
    assign bubble = flush || !instrValid;

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            decValid    <= 1'b0;
            regWriteE   <= 1'b0;
            memWriteE   <= 1'b0;
            aluSrcE     <= 1'b0;
            branchE     <= 1'b0;
            jumpE       <= 1'b0;
            illegalE    <= 1'b0;
            resultSrcE  <= RES_ALU;
            aluControlE <= ALU_ADD;
            immExtE     <= '0;
            rs1E        <= '0;
            rs2E        <= '0;
            rdE         <= '0;
        end
        else if (loadEn)
        begin
            decValid    <= !bubble;
            regWriteE   <= regWriteD && !bubble;
            memWriteE   <= memWriteD && !bubble;
            aluSrcE     <= aluSrcD && !bubble;
            branchE     <= branchD && !bubble;
            jumpE       <= jumpD && !bubble;
            illegalE    <= illegalD && !bubble;
            resultSrcE  <= bubble ? RES_ALU : resultSrcD;
            aluControlE <= bubble ? ALU_ADD : aluControlD;
            immExtE     <= bubble ? '0 : immExtD;
            rs1E        <= bubble ? '0 : rs1D;
            rs2E        <= bubble ? '0 : rs2D;
            rdE         <= bubble ? '0 : rdD;
        end
    end

    // A bubble never carries a side effect
    assert property (@(posedge clk) disable iff (!rstN)
        !decValid |-> !(regWriteE || memWriteE || branchE || jumpE))
    else $error("decodeReg: side-effect control set in a bubble");

    assert property (@(posedge clk) disable iff (!rstN)
        (stall && !flush) |=> $stable(decValid))
    else $error("decodeReg: decValid changed during stall");

endmodule

/* logic/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage
#(
    parameter int XLEN = 32
)
(
    input  logic               clk,
    input  logic               rstN,
    input  logic               instrValid,
    input  logic [31:0]        instr,
    input  logic               stall,
    input  logic               flush,

    output logic               decValid,
    output logic               regWrite,
    output logic               memWrite,
    output logic               aluSrc,
    output logic               branch,
    output logic               jump,
    output logic               illegal,
    output ctrlPkg::resultSrcT resultSrc,
    output ctrlPkg::aluCtrlT   aluControl,
    output logic [XLEN-1:0]    immExt,
    output logic [4:0]         rs1,
    output logic [4:0]         rs2,
    output logic [4:0]         rd
);
    import rvIsaPkg::*;
    import ctrlPkg::*;

    opcodeT          opcode;
    logic            regWriteD;
    immSrcT          immSrcD;
    logic            aluSrcD;
    logic            memWriteD;
    resultSrcT       resultSrcD;
    logic            branchD;
    aluOpT           aluOpD;
    logic            jumpD;
    logic            illegalD;
    aluCtrlT         aluControlD;
    logic [XLEN-1:0] immExtD;

    assign opcode = opcodeT'(instr[6:0]); // Unknown codes fall to the default arm

    mainDecoder uMainDec
    (
        .op        (opcode),
        .regWrite  (regWriteD),
        .immSrc    (immSrcD),
        .aluSrc    (aluSrcD),
        .memWrite  (memWriteD),
        .resultSrc (resultSrcD),
        .branch    (branchD),
        .aluOp     (aluOpD),
        .jump      (jumpD),
        .illegal   (illegalD)
    );

    aluDecoder uAluDec
    (
        .aluOp      (aluOpD),
        .funct3     (instr[14:12]),
        .funct7b5   (instr[30]),
        .op5        (instr[5]),
        .aluControl (aluControlD)
    );

    immExtend #(.XLEN(XLEN)) uImmExt
    (
        .instr  (instr),
        .immSrc (immSrcD),
        .immExt (immExtD)
    );

    decodeReg #(.XLEN(XLEN)) uDecReg
    (
        .clk         (clk),
        .rstN        (rstN),
        .stall       (stall),
        .flush       (flush),
        .instrValid  (instrValid),
        .regWriteD   (regWriteD),
        .memWriteD   (memWriteD),
        .aluSrcD     (aluSrcD),
        .branchD     (branchD),
        .jumpD       (jumpD),
        .illegalD    (illegalD),
        .resultSrcD  (resultSrcD),
        .aluControlD (aluControlD),
        .immExtD     (immExtD),
        .rs1D        (instr[19:15]),
        .rs2D        (instr[24:20]),
        .rdD         (instr[11:7]),
        .decValid    (decValid),
        .regWriteE   (regWrite),
        .memWriteE   (memWrite),
        .aluSrcE     (aluSrc),
        .branchE     (branch),
        .jumpE       (jump),
        .illegalE    (illegal),
        .resultSrcE  (resultSrc),
        .aluControlE (aluControl),
        .immExtE     (immExt),
        .rs1E        (rs1),
        .rs2E        (rs2),
        .rdE         (rd)
    );

endmodule

/* dv/decodeStageTb.sv */
`timescale 1ns/1ps

module decodeStageTb;
    import rvIsaPkg::*;
    import ctrlPkg::*;

    localparam int maxCycles = 3000; // About twice the test length

    typedef struct packed
    {
        logic        decValid;
        logic        regWrite;
        logic        memWrite;
        logic        aluSrc;
        logic        branch;
        logic        jump;
        logic        illegal;
        logic [1:0]  resultSrc;
        logic [3:0]  aluControl;
        logic [31:0] immExt;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
    } decodeT;

    logic        clk = 1'b0;
    logic        rstN;
    logic        instrValid;
    logic [31:0] instr;
    logic        stall;
    logic        flush;

    logic        decValid;
    logic        regWrite;
    logic        memWrite;
    logic        aluSrc;
    logic        branch;
    logic        jump;
    logic        illegal;
    resultSrcT   resultSrc;
    aluCtrlT     aluControl;
    logic [31:0] immExt;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;

    decodeT expQ = '0; // Predicted register contents
    integer seed;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;

    decodeStage #(.XLEN(32)) dut_i
    (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .stall      (stall),
        .flush      (flush),
        .decValid   (decValid),
        .regWrite   (regWrite),
        .memWrite   (memWrite),
        .aluSrc     (aluSrc),
        .branch     (branch),
        .jump       (jump),
        .illegal    (illegal),
        .resultSrc  (resultSrc),
        .aluControl (aluControl),
        .immExt     (immExt),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd)
    );

    always #10 clk = ~clk;

    function automatic logic [3:0] arithAluCtrl(input logic [2:0] f3, input logic b30,
                                                input logic isReg);
        logic [3:0] r;
        case (f3)
            F3_ADD:  r = (isReg && b30) ? ALU_SUB : ALU_ADD; // addi never subtracts
            F3_SLL:  r = ALU_SLL;
            F3_SLT:  r = ALU_SLT;
            F3_SLTU: r = ALU_SLTU;
            F3_XOR:  r = ALU_XOR;
            F3_SR:   r = b30 ? ALU_SRA : ALU_SRL;
            F3_OR:   r = ALU_OR;
            default: r = ALU_AND;
        endcase
        return r;
    endfunction

    function automatic logic [3:0] branchAluCtrl(input logic [2:0] f3);
        logic [3:0] r;
        case (f3)
            F3_BLT, F3_BGE:   r = ALU_SLT;
            F3_BLTU, F3_BGEU: r = ALU_SLTU;
            default:          r = ALU_SUB; // beq, bne
        endcase
        return r;
    endfunction

    // Expected register contents for one valid instruction
    function automatic decodeT refDecode(input logic [31:0] w);
        decodeT d;
        logic signed [31:0] immI;
        logic signed [31:0] immS;
        logic signed [31:0] immB;
        logic signed [31:0] immU;
        logic signed [31:0] immJ;
        immI = $signed({w[31:20], 20'b0}) >>> 20; // Arithmetic shift does the sign fill
        immS = $signed({w[31:25], w[11:7], 20'b0}) >>> 20;
        immB = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0, 19'b0}) >>> 19;
        immU = {w[31:12], 12'b0};
        immJ = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0, 11'b0}) >>> 11;
        d = '0;
        d.decValid   = 1'b1;
        d.rs1        = w[19:15];
        d.rs2        = w[24:20];
        d.rd         = w[11:7];
        d.immExt     = immI; // I format unless the opcode says otherwise
        d.aluControl = ALU_ADD;
        case (w[6:0])
            OP_LOAD:
            begin
                d.regWrite  = 1'b1;
                d.aluSrc    = 1'b1;
                d.resultSrc = RES_MEM;
            end
            OP_STORE:
            begin
                d.memWrite = 1'b1;
                d.aluSrc   = 1'b1;
                d.immExt   = immS;
            end
            OP_REG, OP_IMM:
            begin
                d.regWrite   = 1'b1;
                d.aluSrc     = !w[5];
                d.aluControl = arithAluCtrl(w[14:12], w[30], w[5]);
            end
            OP_BRANCH:
            begin
                d.branch     = 1'b1;
                d.immExt     = immB;
                d.aluControl = branchAluCtrl(w[14:12]);
            end
            OP_AUIPC, OP_LUI:
            begin
                d.regWrite   = 1'b1;
                d.aluSrc     = 1'b1;
                d.immExt     = immU;
                d.aluControl = ALU_PASSB;
                d.resultSrc  = (w[5] == 1'b0) ? RES_PCIMM : RES_ALU; // auipc vs lui
            end
            OP_JALR:
            begin
                d.regWrite  = 1'b1;
                d.aluSrc    = 1'b1;
                d.jump      = 1'b1;
                d.resultSrc = RES_PC4;
            end
            OP_JAL:
            begin
                d.regWrite   = 1'b1;
                d.jump       = 1'b1;
                d.immExt     = immJ;
                d.resultSrc  = RES_PC4;
                d.aluControl = ALU_PASSB;
            end
            default:
            begin
                d.illegal = 1'b1;
            end
        endcase
        return d;
    endfunction

    function automatic logic [31:0] randInstr();
        logic [31:0] w;
        int pick;
        w = $random(seed);
        pick = {$random(seed)} % 13;
        case (pick)
            0:       w[6:0] = OP_LOAD;
            1:       w[6:0] = OP_STORE;
            2:       w[6:0] = OP_REG;
            3:       w[6:0] = OP_IMM;
            4:       w[6:0] = OP_BRANCH;
            5:       w[6:0] = OP_AUIPC;
            6:       w[6:0] = OP_LUI;
            7:       w[6:0] = OP_JALR;
            8:       w[6:0] = OP_JAL;
            9:       w[6:0] = 7'b0001111; // fence
            10:      w[6:0] = 7'b1110011; // system
            11:      w[6:0] = 7'b0000000;
            default: w[6:0] = 7'b1111111;
        endcase
        if (w[6:0] == OP_BRANCH && w[14:13] == 2'b01)
            w[13] = 1'b0; // No branch uses funct3 010 or 011
        return w;
    endfunction

    task automatic driveCycle(input logic v, input logic [31:0] w, input logic s,
                              input logic f);
        @(posedge clk);
        #2;
        instrValid = v;
        instr      = w;
        stall      = s;
        flush      = f;
    endtask

    task automatic checkValue(input string name, input logic [31:0] act,
                              input logic [31:0] exp);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("FAILED time %0t signal %s: got %h, expected %h", $time, name, act, exp);
        end
    endtask

    // Flush beats stall, stall holds, otherwise load or bubble
    always @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            expQ <= '0;
        else if (flush)
            expQ <= '0;
        else if (!stall)
            expQ <= instrValid ? refDecode(instr) : '0;
    end

    always @(negedge clk)
    begin
        checkValue("decValid", 32'(decValid), 32'(expQ.decValid));
        checkValue("regWrite", 32'(regWrite), 32'(expQ.regWrite));
        checkValue("memWrite", 32'(memWrite), 32'(expQ.memWrite));
        checkValue("aluSrc", 32'(aluSrc), 32'(expQ.aluSrc));
        checkValue("branch", 32'(branch), 32'(expQ.branch));
        checkValue("jump", 32'(jump), 32'(expQ.jump));
        checkValue("illegal", 32'(illegal), 32'(expQ.illegal));
        checkValue("resultSrc", 32'(resultSrc), 32'(expQ.resultSrc));
        checkValue("aluControl", 32'(aluControl), 32'(expQ.aluControl));
        checkValue("immExt", immExt, expQ.immExt);
        checkValue("rs1", 32'(rs1), 32'(expQ.rs1));
        checkValue("rs2", 32'(rs2), 32'(expQ.rs2));
        checkValue("rd", 32'(rd), 32'(expQ.rd));
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= maxCycles)
        begin
            $display("Timeout: the test did not finish within %0d cycles", maxCycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial
    begin
        seed       = 93478;
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        stall      = 1'b0;
        flush      = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rstN = 1'b1;

        repeat (3) driveCycle(1'b0, 32'h0, 1'b0, 1'b0);
        if (decValid || regWrite || memWrite || branch || jump || illegal)
        begin
            errors++;
            $display("Outputs left the bubble state before any valid instruction");
        end

        for (int i = 0; i < 900; i++)
            driveCycle(1'b1, randInstr(), 1'b0, 1'b0);

        // Mixed traffic with stalls, flushes and empty slots
        for (int i = 0; i < 500; i++)
            driveCycle(({$random(seed)} % 8) != 0, randInstr(),
                       ({$random(seed)} % 6) == 0, ({$random(seed)} % 12) == 0);

        driveCycle(1'b1, 32'h40c58533, 1'b0, 1'b0); // sub a0, a1, a2
        repeat (4) driveCycle(1'b1, randInstr(), 1'b1, 1'b0);
        driveCycle(1'b1, 32'h4020d093, 1'b0, 1'b0); // srai x1, x1, 2
        driveCycle(1'b1, 32'hfe000ee3, 1'b1, 1'b1);
        driveCycle(1'b1, 32'h00000073, 1'b0, 1'b0); // ecall is illegal here
        repeat (2) driveCycle(1'b0, 32'hffffffff, 1'b0, 1'b0);
        repeat (3) driveCycle(1'b0, 32'h0, 1'b0, 1'b0);
        @(negedge clk);
        #1;

        $display("Checks done: %0d compares, %0d errors", checks, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

/* list.f */
logic/rvIsaPkg.sv
logic/ctrlPkg.sv
logic/mainDecoder.sv
logic/aluDecoder.sv
logic/immExtend.sv
logic/decodeReg.sv
logic/decodeStage.sv
dv/decodeStageTb.sv

/* run.sh */
#!/bin/bash
# Build and run the decode stage testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module decodeStageTb \
    --Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
    exit 0
fi
exit 1
